// ==== histBuilder.sv ====
`timescale 1ns/100ps
`include "hist_consts.svh"

module histBuilder (
    input  logic            clk,
    input  logic            arstN,
    input  histPkg::sampleT sample,
    input  logic            sampleValid,
    output logic            sampleReady,
    input  logic            scanBusy,
    input  logic            ramReady,
    output histPkg::wbReqT  wbReq,
    input  histPkg::wbRspT  wbRsp
);
    import histPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE
    } buildStateT;

    buildStateT           state;
    histAddrU             binAddr;
    logic [`CNT_BITS-1:0] binCnt;
    logic                 take;
    logic                 cntFull;

    // one sample in flight, none during a scan or the RAM clear
    assign sampleReady = (state == IDLE) && ramReady && !scanBusy;
    assign take        = sampleValid && sampleReady;
    assign cntFull     = (wbRsp.data == {`CNT_BITS{1'b1}});

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        state <= READ;
                    end
                end
                READ: begin
                    if (wbRsp.ack) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (wbRsp.ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // accepted sample and incremented count
    always_ff @(posedge clk) begin
        if (take) begin
            binAddr.field.pixel <= sample.pixel;
            binAddr.field.bin   <= sample.code[`NP-1 -: `BIN_BITS];
        end
        if ((state == READ) && wbRsp.ack) begin
            // saturate instead of wrapping to zero
            binCnt <= cntFull ? wbRsp.data : wbRsp.data + 1'b1;
        end
    end

    // cyc held across read and write so the grant stays
    always_comb begin
        wbReq      = '0;
        wbReq.cyc  = (state != IDLE);
        wbReq.stb  = (state != IDLE);
        wbReq.we   = (state == WRITE);
        wbReq.addr = binAddr;
        wbReq.data = binCnt;
    end

endmodule

// ==== histBuilderTb.sv ====
`timescale 1ns/100ps
`include "hist_consts.svh"

module histBuilderTb;
    import histPkg::*;

    localparam int binNum       = 1 << `BIN_BITS;
    localparam int maxCount     = (1 << `CNT_BITS) - 1;
    localparam int readyTimeout = 200;
    localparam int scanTimeout  = 2000;

    logic   clk;
    logic   arstN;
    sampleT sample;
    logic   sampleValid;
    logic   sampleReady;
    logic   acqDone;
    peakT   peak;
    logic   peakValid;
    logic   scanBusy;

    // reference histograms with one count per pixel and bin
    int     refHist [`PIXEL_NUM][binNum];
    peakT   seenPeak [`PIXEL_NUM];
    string  testName;
    int     testErrors;
    int     totalErrors;
    int     testsRun;
    int     failedTests;
    int     nextPixel;
    int     pulseCount;

    sifhTop i_dut (
        .clk        (clk),
        .arstN      (arstN),
        .sample     (sample),
        .sampleValid(sampleValid),
        .sampleReady(sampleReady),
        .acqDone    (acqDone),
        .peak       (peak),
        .peakValid  (peakValid),
        .scanBusy   (scanBusy)
    );

    always #2 clk = ~clk;

    // peak of one pixel with the lowest bin winning a tie
    // the pixel's bins then read as zero
    function automatic peakT expectedPeak(input int pix);
        peakT res;
        res.pixel = `PIX_BITS'(pix);
        res.bin   = '0;
        res.count = `CNT_BITS'(refHist[pix][0]);
        for (int b = 1; b < binNum; b++) begin
            if (refHist[pix][b] > int'(res.count)) begin
                res.bin   = `BIN_BITS'(b);
                res.count = `CNT_BITS'(refHist[pix][b]);
            end
        end
        for (int b = 0; b < binNum; b++) begin
            refHist[pix][b] = 0;
        end
        return res;
    endfunction

    // checks every peakValid pulse at the falling edge where outputs are stable
    always @(negedge clk) begin : peakCheck
        peakT expPeak;
        if (arstN) begin
            assert (!(scanBusy && sampleReady)) else begin
                $display("%s: sampleReady was high during a scan", testName);
                testErrors++;
            end
            if (peakValid) begin
                pulseCount++;
                assert (scanBusy && nextPixel < `PIXEL_NUM) else begin
                    $display("%s: unexpected peakValid pulse outside the scan", testName);
                    testErrors++;
                end
                if (nextPixel < `PIXEL_NUM) begin
                    expPeak = expectedPeak(nextPixel);
                    seenPeak[nextPixel] = peak;
                    assert (peak == expPeak) else begin
                        $write("FAILED %s: expected pixel %0d bin %0d count %0d, ",
                               testName, expPeak.pixel, expPeak.bin, expPeak.count);
                        $display("actual pixel %0d bin %0d count %0d",
                                 peak.pixel, peak.bin, peak.count);
                        testErrors++;
                    end
                    nextPixel++;
                end
            end
        end
    end

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic finishTest();
        testsRun++;
        totalErrors += testErrors;
        if (testErrors == 0) begin
            $display("test %s: ok", testName);
        end else begin
            failedTests++;
            $display("test %s: %0d errors", testName, testErrors);
        end
    endtask

    // called on a falling edge and returns on the falling edge after the handshake
    task automatic sendSample(input int pix, input int code);
        int waitCnt;
        int bin;
        waitCnt      = 0;
        bin          = code >> (`NP - `BIN_BITS);
        sample.pixel = `PIX_BITS'(pix);
        sample.code  = `NP'(code);
        sampleValid  = 1'b1;
        while (!sampleReady && waitCnt < readyTimeout) begin
            @(negedge clk);
            waitCnt++;
        end
        assert (sampleReady) else begin
            $display("%s: timeout, sampleReady stayed low with a sample waiting", testName);
            testErrors++;
        end
        // taken on the next rising edge
        if (sampleReady && refHist[pix][bin] < maxCount) begin
            refHist[pix][bin]++;
        end
        @(negedge clk);
        sampleValid = 1'b0;
    endtask

    task automatic runScan();
        int waitCnt;
        waitCnt = 0;
        while (!sampleReady && waitCnt < readyTimeout) begin
            @(negedge clk);
            waitCnt++;
        end
        assert (sampleReady) else begin
            $display("%s: timeout, builder never went idle before acqDone", testName);
            testErrors++;
        end
        nextPixel  = 0;
        pulseCount = 0;
        acqDone    = 1'b1;
        @(negedge clk);
        acqDone = 1'b0;
        assert (scanBusy) else begin
            $display("%s: scanBusy did not rise after acqDone", testName);
            testErrors++;
        end
        // a sample held during the scan must not be taken
        sample.pixel = `PIX_BITS'($urandom % `PIXEL_NUM);
        sample.code  = `NP'($urandom);
        sampleValid  = 1'b1;
        waitCnt      = 0;
        while (scanBusy && waitCnt < scanTimeout) begin
            @(negedge clk);
            waitCnt++;
        end
        sampleValid = 1'b0;
        assert (!scanBusy) else begin
            $display("%s: timeout, scanBusy never fell", testName);
            testErrors++;
        end
        assert (pulseCount == `PIXEL_NUM) else begin
            $display("FAILED %s: peakValid pulses expected %0d actual %0d",
                     testName, `PIXEL_NUM, pulseCount);
            testErrors++;
        end
    endtask

    initial begin
        int dirCodes [12] = '{108, 511, 1022, 200, 90, 1023, 130, 700, 701, 90, 1000, 64};
        int dirPix [12]   = '{0, 1, 2, 0, 0, 2, 1, 1, 1, 0, 2, 1};
        int clrCodes [10] = '{300, 301, 900, 17, 18, 19, 640, 650, 660, 255};
        int clrPix [10]   = '{2, 2, 0, 1, 1, 1, 0, 0, 1, 2};
        clk         = 1'b0;
        arstN       = 1'b0;
        sample      = '0;
        sampleValid = 1'b0;
        acqDone     = 1'b0;
        totalErrors = 0;
        testsRun    = 0;
        failedTests = 0;
        void'($urandom(32'h96a763f3));
        repeat (5) @(negedge clk);
        arstN = 1'b1;

        startTest("directed");
        assert (!peakValid && !scanBusy && !sampleReady) else begin
            $display("%s: outputs not idle after reset", testName);
            testErrors++;
        end
        for (int i = 0; i < 12; i++) begin
            sendSample(dirPix[i], dirCodes[i]);
        end
        runScan();
        finishTest();

        startTest("clearing");
        for (int i = 0; i < 10; i++) begin
            sendSample(clrPix[i], clrCodes[i]);
        end
        runScan();
        finishTest();

        startTest("saturation");
        sendSample(0, 77);
        sendSample(2, 999);
        // bin 5 of pixel 1
        repeat (300) sendSample(1, 341);
        runScan();
        assert (seenPeak[1].bin == 5 && seenPeak[1].count == maxCount) else begin
            $display("FAILED %s: expected bin 5 count %0d, actual bin %0d count %0d",
                     testName, maxCount, seenPeak[1].bin, seenPeak[1].count);
            testErrors++;
        end
        finishTest();

        startTest("ties");
        repeat (3) sendSample(0, 9 << 6);
        repeat (3) sendSample(0, (4 << 6) + 5);
        repeat (2) sendSample(2, 12 << 6);
        repeat (2) sendSample(2, 2 << 6);
        runScan();
        assert (seenPeak[0].bin == 4 && seenPeak[0].count == 3) else begin
            $display("FAILED %s: expected bin 4 count 3, actual bin %0d count %0d",
                     testName, seenPeak[0].bin, seenPeak[0].count);
            testErrors++;
        end
        assert (seenPeak[1].bin == 0 && seenPeak[1].count == 0) else begin
            $display("FAILED %s: expected bin 0 count 0, actual bin %0d count %0d",
                     testName, seenPeak[1].bin, seenPeak[1].count);
            testErrors++;
        end
        finishTest();

        startTest("random");
        for (int i = 0; i < 200; i++) begin
            repeat ($urandom % 4) @(negedge clk);
            sendSample($urandom % `PIXEL_NUM, $urandom % (1 << `NP));
        end
        runScan();
        finishTest();

        $display("tests run %0d, tests with errors %0d, errors %0d",
                 testsRun, failedTests, totalErrors);
        if (totalErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== histPkg.sv ====
`include "hist_consts.svh"

package histPkg;

    // one tagged time code from the detector
    typedef struct packed {
        logic [`PIX_BITS-1:0] pixel;
        logic [`NP-1:0]       code;
    } sampleT;

    // per pixel result of the scan
    typedef struct packed {
        logic [`PIX_BITS-1:0] pixel;
        logic [`BIN_BITS-1:0] bin;
        logic [`CNT_BITS-1:0] count;
    } peakT;

    // address fields, pixel on top
    typedef struct packed {
        logic [`PIX_BITS-1:0] pixel;
        logic [`BIN_BITS-1:0] bin;
    } histFieldT;

    // same address word seen flat by the RAM and the scan counter
    typedef union packed {
        logic [`ADDR_BITS-1:0] flat;
        histFieldT             field;
    } histAddrU;

    // wishbone classic master request
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        histAddrU             addr;
        logic [`CNT_BITS-1:0] data;
    } wbReqT;

    // wishbone classic slave response
    typedef struct packed {
        logic                 ack;
        logic [`CNT_BITS-1:0] data;
    } wbRspT;

endpackage

// ==== histRam.sv ====
`timescale 1ns/100ps
`include "hist_consts.svh"

module histRam (
    input  logic           clk,
    input  logic           arstN,
    input  histPkg::wbReqT wbReq,
    output histPkg::wbRspT wbRsp,
    output logic           ramReady
);
    logic [`CNT_BITS-1:0]  mem [0:(1 << `ADDR_BITS)-1];
    logic [`ADDR_BITS-1:0] clrAddr;
    logic [`CNT_BITS-1:0]  rdData;
    logic                  ackQ;
    logic                  access;

    // new strobe only, so every ack is a single cycle
    assign access = ramReady && wbReq.cyc && wbReq.stb && !ackQ;

    // clear sweep, then the ack register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            clrAddr  <= '0;
            ramReady <= 1'b0;
            ackQ     <= 1'b0;
        end else if (!ramReady) begin
            clrAddr <= clrAddr + 1'b1;
            if (clrAddr == '1) begin
                ramReady <= 1'b1;
            end
        end else begin
            ackQ <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (!ramReady) begin
            mem[clrAddr] <= '0;
        end else if (access && wbReq.we) begin
            mem[wbReq.addr.flat] <= wbReq.data;
        end
        // read data lines up with the ack
        if (access) begin
            rdData <= mem[wbReq.addr.flat];
        end
    end

    assign wbRsp.ack  = ackQ;
    assign wbRsp.data = rdData;

endmodule

// ==== hist_consts.svh ====
`ifndef HIST_CONSTS_SVH
`define HIST_CONSTS_SVH

// shared sizing of the histogram subsystem

// time code width from the TDC
`define NP 10

// upper code bits that pick a bin
// 16 bins per pixel
`define BIN_BITS 4

// pixels sharing the one RAM
`define PIXEL_NUM 3

// pixel index width
`define PIX_BITS 2

// bin count width
// counts saturate at all ones
`define CNT_BITS 8

// RAM word address
// pixel in the upper bits, bin in the lower bits
`define ADDR_BITS (`PIX_BITS + `BIN_BITS)

`endif

// ==== peakFinder.sv ====
`timescale 1ns/100ps
`include "hist_consts.svh"

module peakFinder (
    input  logic           clk,
    input  logic           arstN,
    input  logic           acqDone,
    output logic           scanBusy,
    output histPkg::wbReqT wbReq,
    input  histPkg::wbRspT wbRsp,
    output histPkg::peakT  peak,
    output logic           peakValid
);
    import histPkg::*;

    typedef enum logic [2:0] {
        IDLE,
        READ,
        WRITE,
        NEXT,
        DONE
    } scanStateT;

    scanStateT            state;
    histAddrU             scanAddr;
    logic [`BIN_BITS-1:0] maxBin;
    logic [`CNT_BITS-1:0] maxCnt;
    logic                 lastBin;
    logic                 lastPixel;
    logic                 takeNew;

    assign lastBin   = (scanAddr.field.bin == {`BIN_BITS{1'b1}});
    assign lastPixel = (scanAddr.field.pixel == `PIX_BITS'(`PIXEL_NUM - 1));

    // bin 0 restarts the running maximum
    // strictly greater keeps the lowest bin on a tie
    assign takeNew = (scanAddr.field.bin == '0) || (wbRsp.data > maxCnt);

    // DONE covers the last peakValid cycle
    assign scanBusy = (state != IDLE);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= IDLE;
            scanAddr  <= '0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= 1'b0;
            case (state)
                IDLE: begin
                    if (acqDone) begin
                        scanAddr.flat <= '0;
                        state         <= READ;
                    end
                end
                READ: begin
                    if (wbRsp.ack) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (wbRsp.ack) begin
                        peakValid <= lastBin;
                        if (lastBin && lastPixel) begin
                            state <= DONE;
                        end else begin
                            scanAddr.flat <= scanAddr.flat + 1'b1;
                            state         <= NEXT;
                        end
                    end
                end
                // cyc low between words
                NEXT: begin
                    state <= READ;
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // running maximum and the reported peak
    always_ff @(posedge clk) begin
        if ((state == READ) && wbRsp.ack && takeNew) begin
            maxBin <= scanAddr.field.bin;
            maxCnt <= wbRsp.data;
        end
        if ((state == WRITE) && wbRsp.ack && lastBin) begin
            peak.pixel <= scanAddr.field.pixel;
            peak.bin   <= maxBin;
            peak.count <= maxCnt;
        end
    end

    // read the word, then clear it, in one held cycle
    always_comb begin
        wbReq      = '0;
        wbReq.cyc  = (state == READ) || (state == WRITE);
        wbReq.stb  = (state == READ) || (state == WRITE);
        wbReq.we   = (state == WRITE);
        wbReq.addr = scanAddr;
    end

endmodule

// ==== sifhTop.sv ====
`timescale 1ns/100ps

module sifhTop (
    input  logic            clk,
    input  logic            arstN,
    input  histPkg::sampleT sample,
    input  logic            sampleValid,
    output logic            sampleReady,
    input  logic            acqDone,
    output histPkg::peakT   peak,
    output logic            peakValid,
    output logic            scanBusy
);
    import histPkg::*;

    wbReqT builderReq;
    wbRspT builderRsp;
    wbReqT scanReq;
    wbRspT scanRsp;
    wbReqT ramReq;
    wbRspT ramRsp;
    logic  ramReady;

    histBuilder u_builder (
        .clk        (clk),
        .arstN      (arstN),
        .sample     (sample),
        .sampleValid(sampleValid),
        .sampleReady(sampleReady),
        .scanBusy   (scanBusy),
        .ramReady   (ramReady),
        .wbReq      (builderReq),
        .wbRsp      (builderRsp)
    );

    // scanBusy also blocks new samples in the builder
    peakFinder u_peak (
        .clk      (clk),
        .arstN    (arstN),
        .acqDone  (acqDone),
        .scanBusy (scanBusy),
        .wbReq    (scanReq),
        .wbRsp    (scanRsp),
        .peak     (peak),
        .peakValid(peakValid)
    );

    wbArbiter u_arb (
        .clk       (clk),
        .arstN     (arstN),
        .builderReq(builderReq),
        .builderRsp(builderRsp),
        .scanReq   (scanReq),
        .scanRsp   (scanRsp),
        .ramReq    (ramReq),
        .ramRsp    (ramRsp)
    );

    histRam u_ram (
        .clk     (clk),
        .arstN   (arstN),
        .wbReq   (ramReq),
        .wbRsp   (ramRsp),
        .ramReady(ramReady)
    );

endmodule

// ==== tb.f ====
+incdir+.
histPkg.sv
histRam.sv
wbArbiter.sv
histBuilder.sv
peakFinder.sv
sifhTop.sv
histBuilderTb.sv

// ==== wbArbiter.sv ====
`timescale 1ns/100ps

module wbArbiter (
    input  logic           clk,
    input  logic           arstN,
    input  histPkg::wbReqT builderReq,
    output histPkg::wbRspT builderRsp,
    input  histPkg::wbReqT scanReq,
    output histPkg::wbRspT scanRsp,
    output histPkg::wbReqT ramReq,
    input  histPkg::wbRspT ramRsp
);
    // one-hot grant with bit 0 for the builder and bit 1 for the peak finder
    logic [1:0] grant;
    // set when the peak finder held the bus last
    logic       lastServed;
    logic       pickScan;
    logic       ownerDone;

    // on a tie the master not served last wins
    assign pickScan = scanReq.cyc && (!builderReq.cyc || !lastServed);

    // grant ends once the owner drops cyc
    assign ownerDone = (grant[0] && !builderReq.cyc) || (grant[1] && !scanReq.cyc);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            grant      <= 2'b00;
            lastServed <= 1'b1;
        end else if (grant == 2'b00) begin
            if (builderReq.cyc || scanReq.cyc) begin
                grant <= pickScan ? 2'b10 : 2'b01;
            end
        end else if (ownerDone) begin
            grant      <= 2'b00;
            lastServed <= grant[1];
        end
    end

    // request path stays idle when nobody owns the bus
    always_comb begin
        ramReq = '0;
        if (grant[0]) begin
            ramReq = builderReq;
        end else if (grant[1]) begin
            ramReq = scanReq;
        end
    end

    // read data goes to both masters and ack to the owner only
    always_comb begin
        builderRsp     = ramRsp;
        builderRsp.ack = ramRsp.ack && grant[0];
        scanRsp        = ramRsp;
        scanRsp.ack    = ramRsp.ack && grant[1];
    end

endmodule
